// File: include/decode_config.svh
`ifndef DECODE_CONFIG_SVH
`define DECODE_CONFIG_SVH

// datapath word width in bits.
`define XLEN 32

// architectural integer registers, x0 included.
`define REG_COUNT 32

// value seen on the ex_pc output while the pipe is in reset.
`define RESET_PC 32'h0000_0000

`endif

// File: logic/rv32i_isa_pkg.sv
`include "decode_config.svh"

package rv32i_isa_pkg;

    // data and instruction words.
    typedef logic [`XLEN-1:0] rv32i_word;

    // register index, x0 through x31.
    typedef logic [$clog2(`REG_COUNT)-1:0] rv32i_reg;

    // minor opcode field of R and I type arithmetic.
    typedef logic [2:0] rv32i_funct3;

    // major opcodes; anything else decodes as illegal.
    typedef enum logic [6:0] {
        op_lui    = 7'b0110111,
        op_auipc  = 7'b0010111,
        op_jal    = 7'b1101111,
        op_jalr   = 7'b1100111,
        op_branch = 7'b1100011,
        op_load   = 7'b0000011,
        op_store  = 7'b0100011,
        op_op_imm = 7'b0010011,
        op_op     = 7'b0110011
    } rv32i_opcode;

    localparam rv32i_funct3 F3_ADD_SUB = 3'b000;
    localparam rv32i_funct3 F3_SLL     = 3'b001;
    localparam rv32i_funct3 F3_SLT     = 3'b010;
    localparam rv32i_funct3 F3_SLTU    = 3'b011;
    localparam rv32i_funct3 F3_XOR     = 3'b100;
    localparam rv32i_funct3 F3_SRL_SRA = 3'b101;
    localparam rv32i_funct3 F3_OR      = 3'b110;
    localparam rv32i_funct3 F3_AND     = 3'b111;

    // alu operations; pass_b forwards operand b for lui.
    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

endpackage

// File: logic/pipe_stage_pkg.sv
package pipe_stage_pkg;

    // immediate format chosen by the decoder.
    typedef enum logic [2:0] {
        imm_none,
        imm_i,
        imm_s,
        imm_b,
        imm_u,
        imm_j
    } imm_fmt_t;

    // bit positions inside the packed control word, lsb first.
    localparam int CTRL_ILLEGAL     = 0;
    localparam int CTRL_JUMP        = 1;
    localparam int CTRL_BRANCH      = 2;
    localparam int CTRL_MEM_WRITE   = 3;
    localparam int CTRL_MEM_READ    = 4;
    localparam int CTRL_REG_WRITE   = 5;
    localparam int CTRL_ALU_SRC_PC  = 6;
    localparam int CTRL_ALU_SRC_IMM = 7;
    localparam int CTRL_ALU_OP_LSB  = 8;

    // alu_op sits on top of the single bit flags.
    localparam int CTRL_W = CTRL_ALU_OP_LSB + $bits(rv32i_isa_pkg::alu_op_t);

    // {alu_op, alu_src_imm, alu_src_pc, reg_write,
    //  mem_read, mem_write, branch, jump, illegal}
    typedef logic [CTRL_W-1:0] ctrl_word_t;

endpackage

// File: logic/control_word.sv
`timescale 1ns/1ns

module control_word (
    input  rv32i_isa_pkg::rv32i_word   instr,
    output pipe_stage_pkg::ctrl_word_t ctrl,
    output pipe_stage_pkg::imm_fmt_t   imm_fmt
);
    rv32i_isa_pkg::rv32i_opcode opcode;
    rv32i_isa_pkg::rv32i_funct3 funct3;
    logic                       funct7_b5;

    rv32i_isa_pkg::alu_op_t alu_op;
    logic alu_src_imm;
    logic alu_src_pc;
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic branch;
    logic jump;
    logic illegal;

    // sub only exists in register form; sra in both forms.
    function automatic rv32i_isa_pkg::alu_op_t arith_op(
        input rv32i_isa_pkg::rv32i_funct3 f3,
        input logic                       alt,
        input logic                       reg_form
    );
        case (f3)
            rv32i_isa_pkg::F3_ADD_SUB:
                arith_op = (alt && reg_form) ? rv32i_isa_pkg::alu_sub : rv32i_isa_pkg::alu_add;
            rv32i_isa_pkg::F3_SLL:  arith_op = rv32i_isa_pkg::alu_sll;
            rv32i_isa_pkg::F3_SLT:  arith_op = rv32i_isa_pkg::alu_slt;
            rv32i_isa_pkg::F3_SLTU: arith_op = rv32i_isa_pkg::alu_sltu;
            rv32i_isa_pkg::F3_XOR:  arith_op = rv32i_isa_pkg::alu_xor;
            rv32i_isa_pkg::F3_SRL_SRA:
                arith_op = alt ? rv32i_isa_pkg::alu_sra : rv32i_isa_pkg::alu_srl;
            rv32i_isa_pkg::F3_OR:   arith_op = rv32i_isa_pkg::alu_or;
            default:                arith_op = rv32i_isa_pkg::alu_and;
        endcase
    endfunction

    assign opcode    = rv32i_isa_pkg::rv32i_opcode'(instr[6:0]);
    assign funct3    = instr[14:12];
    assign funct7_b5 = instr[30];

    always_comb begin
        // defaults describe a harmless nop.
        alu_op      = rv32i_isa_pkg::alu_add;
        alu_src_imm = 1'b0;
        alu_src_pc  = 1'b0;
        reg_write   = 1'b0;
        mem_read    = 1'b0;
        mem_write   = 1'b0;
        branch      = 1'b0;
        jump        = 1'b0;
        illegal     = 1'b0;
        imm_fmt     = pipe_stage_pkg::imm_none;
        case (opcode)
            rv32i_isa_pkg::op_lui: begin
                imm_fmt     = pipe_stage_pkg::imm_u;
                alu_op      = rv32i_isa_pkg::alu_pass_b;
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            rv32i_isa_pkg::op_auipc: begin
                imm_fmt     = pipe_stage_pkg::imm_u;
                alu_src_imm = 1'b1;
                alu_src_pc  = 1'b1;
                reg_write   = 1'b1;
            end
            rv32i_isa_pkg::op_jal: begin
                // target is pc plus offset.
                imm_fmt     = pipe_stage_pkg::imm_j;
                alu_src_imm = 1'b1;
                alu_src_pc  = 1'b1;
                reg_write   = 1'b1;
                jump        = 1'b1;
            end
            rv32i_isa_pkg::op_jalr: begin
                imm_fmt     = pipe_stage_pkg::imm_i;
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
                jump        = 1'b1;
            end
            rv32i_isa_pkg::op_branch: begin
                imm_fmt     = pipe_stage_pkg::imm_b;
                alu_src_imm = 1'b1;
                alu_src_pc  = 1'b1;
                branch      = 1'b1;
            end
            rv32i_isa_pkg::op_load: begin
                imm_fmt     = pipe_stage_pkg::imm_i;
                alu_src_imm = 1'b1;
                mem_read    = 1'b1;
                reg_write   = 1'b1;
            end
            rv32i_isa_pkg::op_store: begin
                imm_fmt     = pipe_stage_pkg::imm_s;
                alu_src_imm = 1'b1;
                mem_write   = 1'b1;
            end
            rv32i_isa_pkg::op_op_imm: begin
                imm_fmt     = pipe_stage_pkg::imm_i;
                alu_op      = arith_op(funct3, funct7_b5, 1'b0);
                alu_src_imm = 1'b1;
                reg_write   = 1'b1;
            end
            rv32i_isa_pkg::op_op: begin
                alu_op    = arith_op(funct3, funct7_b5, 1'b1);
                reg_write = 1'b1;
            end
            default: illegal = 1'b1;
        endcase
    end

    always_comb begin
        ctrl = '0;
        ctrl[pipe_stage_pkg::CTRL_W-1:pipe_stage_pkg::CTRL_ALU_OP_LSB] = alu_op;
        ctrl[pipe_stage_pkg::CTRL_ALU_SRC_IMM] = alu_src_imm;
        ctrl[pipe_stage_pkg::CTRL_ALU_SRC_PC]  = alu_src_pc;
        ctrl[pipe_stage_pkg::CTRL_REG_WRITE]   = reg_write;
        ctrl[pipe_stage_pkg::CTRL_MEM_READ]    = mem_read;
        ctrl[pipe_stage_pkg::CTRL_MEM_WRITE]   = mem_write;
        ctrl[pipe_stage_pkg::CTRL_BRANCH]      = branch;
        ctrl[pipe_stage_pkg::CTRL_JUMP]        = jump;
        ctrl[pipe_stage_pkg::CTRL_ILLEGAL]     = illegal;
    end

endmodule

// File: logic/regfile.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module regfile (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      load,
    input  rv32i_isa_pkg::rv32i_reg   dest,
    input  rv32i_isa_pkg::rv32i_word  wdata,
    input  rv32i_isa_pkg::rv32i_reg   src_a,
    input  rv32i_isa_pkg::rv32i_reg   src_b,
    output rv32i_isa_pkg::rv32i_word  reg_a,
    output rv32i_isa_pkg::rv32i_word  reg_b
);
    // x0 has no storage.
    rv32i_isa_pkg::rv32i_word regs [1:`REG_COUNT-1];

    logic write_en;

    assign write_en = load && (dest != '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 1; i < `REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[dest] <= wdata;
        end
    end

    // write-through so decode sees the value being written back.
    function automatic rv32i_isa_pkg::rv32i_word read_port(input rv32i_isa_pkg::rv32i_reg src);
        if (src == '0) begin
            read_port = '0;
        end else if (write_en && (dest == src)) begin
            read_port = wdata;
        end else begin
            read_port = regs[src];
        end
    endfunction

    assign reg_a = read_port(src_a);
    assign reg_b = read_port(src_b);

endmodule

// File: logic/id_ex_if.sv
`timescale 1ns/1ns

interface id_ex_if;
    logic                       valid;
    rv32i_isa_pkg::rv32i_word   pc;
    rv32i_isa_pkg::rv32i_word   rs1_data;
    rv32i_isa_pkg::rv32i_word   rs2_data;
    rv32i_isa_pkg::rv32i_word   imm;
    rv32i_isa_pkg::rv32i_reg    rd;
    pipe_stage_pkg::ctrl_word_t ctrl;

    // decode produces the record.
    modport decode (
        output valid, pc, rs1_data, rs2_data, imm, rd, ctrl
    );

    // the ID/EX register consumes it.
    modport buffer (
        input valid, pc, rs1_data, rs2_data, imm, rd, ctrl
    );

endinterface

// File: logic/i_decode.sv
`timescale 1ns/1ns

module i_decode (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  rv32i_isa_pkg::rv32i_word in_pc,
    input  rv32i_isa_pkg::rv32i_word in_instr,
    input  logic                     wb_load,
    input  rv32i_isa_pkg::rv32i_reg  wb_rd,
    input  rv32i_isa_pkg::rv32i_word wb_data,
    id_ex_if.decode                  dec
);
    rv32i_isa_pkg::rv32i_reg  rs1;
    rv32i_isa_pkg::rv32i_reg  rs2;
    rv32i_isa_pkg::rv32i_word i_imm;
    rv32i_isa_pkg::rv32i_word s_imm;
    rv32i_isa_pkg::rv32i_word b_imm;
    rv32i_isa_pkg::rv32i_word u_imm;
    rv32i_isa_pkg::rv32i_word j_imm;
    pipe_stage_pkg::imm_fmt_t imm_fmt;

    assign rs1 = in_instr[19:15];
    assign rs2 = in_instr[24:20];

    // every format takes its sign from bit 31.
    assign i_imm = {{21{in_instr[31]}}, in_instr[30:20]};
    assign s_imm = {{21{in_instr[31]}}, in_instr[30:25], in_instr[11:7]};
    assign b_imm = {{20{in_instr[31]}}, in_instr[7], in_instr[30:25], in_instr[11:8], 1'b0};
    assign u_imm = {in_instr[31:12], 12'h000};
    assign j_imm = {{12{in_instr[31]}}, in_instr[19:12], in_instr[20], in_instr[30:21], 1'b0};

    always_comb begin
        case (imm_fmt)
            pipe_stage_pkg::imm_i: dec.imm = i_imm;
            pipe_stage_pkg::imm_s: dec.imm = s_imm;
            pipe_stage_pkg::imm_b: dec.imm = b_imm;
            pipe_stage_pkg::imm_u: dec.imm = u_imm;
            pipe_stage_pkg::imm_j: dec.imm = j_imm;
            default:               dec.imm = '0;
        endcase
    end

    assign dec.valid = in_valid;
    assign dec.pc    = in_pc;
    assign dec.rd    = in_instr[11:7];

    control_word u_control_word (
        .instr   (in_instr),
        .ctrl    (dec.ctrl),
        .imm_fmt (imm_fmt)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .load  (wb_load),
        .dest  (wb_rd),
        .wdata (wb_data),
        .src_a (rs1),
        .src_b (rs2),
        .reg_a (dec.rs1_data),
        .reg_b (dec.rs2_data)
    );

endmodule

// File: logic/id_ex_buffer.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module id_ex_buffer (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       stall,
    input  logic                       flush,
    id_ex_if.buffer                    dec,
    output logic                       ex_valid,
    output rv32i_isa_pkg::rv32i_word   ex_pc,
    output rv32i_isa_pkg::rv32i_word   ex_rs1_data,
    output rv32i_isa_pkg::rv32i_word   ex_rs2_data,
    output rv32i_isa_pkg::rv32i_word   ex_imm,
    output rv32i_isa_pkg::rv32i_reg    ex_rd,
    output pipe_stage_pkg::ctrl_word_t ex_ctrl
);
    logic load_en;
    logic take;

    // flush overrides stall.
    assign load_en = flush || !stall;

    // a bubble is loaded on flush or when decode has nothing valid.
    assign take = dec.valid && !flush;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ex_valid <= 1'b0;
            ex_ctrl  <= '0;
            ex_pc    <= `RESET_PC;
        end else if (load_en) begin
            ex_valid <= take;
            ex_ctrl  <= take ? dec.ctrl : '0;
            ex_pc    <= dec.pc;
        end
    end

    // operand payload follows the same load enable.
    always_ff @(posedge clk) begin
        if (load_en) begin
            ex_rs1_data <= dec.rs1_data;
            ex_rs2_data <= dec.rs2_data;
            ex_imm      <= dec.imm;
            ex_rd       <= dec.rd;
        end
    end

endmodule

// File: logic/decode_stage_top.sv
`timescale 1ns/1ns

module decode_stage_top (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  rv32i_isa_pkg::rv32i_word   in_pc,
    input  rv32i_isa_pkg::rv32i_word   in_instr,
    input  logic                       stall,
    input  logic                       flush,
    input  logic                       wb_load,
    input  rv32i_isa_pkg::rv32i_reg    wb_rd,
    input  rv32i_isa_pkg::rv32i_word   wb_data,
    output logic                       ex_valid,
    output rv32i_isa_pkg::rv32i_word   ex_pc,
    output rv32i_isa_pkg::rv32i_word   ex_rs1_data,
    output rv32i_isa_pkg::rv32i_word   ex_rs2_data,
    output rv32i_isa_pkg::rv32i_word   ex_imm,
    output rv32i_isa_pkg::rv32i_reg    ex_rd,
    output pipe_stage_pkg::ctrl_word_t ex_ctrl
);
    // decoded record between the stage and its output register.
    id_ex_if id_ex ();

    i_decode u_i_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_pc    (in_pc),
        .in_instr (in_instr),
        .wb_load  (wb_load),
        .wb_rd    (wb_rd),
        .wb_data  (wb_data),
        .dec      (id_ex.decode)
    );

    // single register stage, so one clock of latency.
    id_ex_buffer u_id_ex_buffer (
        .clk         (clk),
        .rst_n       (rst_n),
        .stall       (stall),
        .flush       (flush),
        .dec         (id_ex.buffer),
        .ex_valid    (ex_valid),
        .ex_pc       (ex_pc),
        .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data),
        .ex_imm      (ex_imm),
        .ex_rd       (ex_rd),
        .ex_ctrl     (ex_ctrl)
    );

endmodule

// File: verification/decode_props.sv
`timescale 1ns/1ns

module decode_props (
    input logic                       clk,
    input logic                       rst_n,
    input logic                       stall,
    input logic                       flush,
    input logic                       ex_valid,
    input rv32i_isa_pkg::rv32i_word   ex_pc,
    input rv32i_isa_pkg::rv32i_word   ex_rs1_data,
    input rv32i_isa_pkg::rv32i_word   ex_rs2_data,
    input rv32i_isa_pkg::rv32i_word   ex_imm,
    input rv32i_isa_pkg::rv32i_reg    ex_rd,
    input pipe_stage_pkg::ctrl_word_t ex_ctrl
);
    logic reg_write;
    logic mem_read;
    logic mem_write;
    logic branch;
    logic jump;

    assign reg_write = ex_ctrl[pipe_stage_pkg::CTRL_REG_WRITE];
    assign mem_read  = ex_ctrl[pipe_stage_pkg::CTRL_MEM_READ];
    assign mem_write = ex_ctrl[pipe_stage_pkg::CTRL_MEM_WRITE];
    assign branch    = ex_ctrl[pipe_stage_pkg::CTRL_BRANCH];
    assign jump      = ex_ctrl[pipe_stage_pkg::CTRL_JUMP];

    // a flushed slot carries no side effects.
    flush_gives_bubble: assert property (@(posedge clk) disable iff (!rst_n)
        flush |=> !ex_valid && !reg_write && !mem_read && !mem_write && !branch && !jump)
        else $error("ID/EX register is not a bubble after a flush");

    stall_holds_outputs: assert property (@(posedge clk) disable iff (!rst_n)
        (stall && !flush) |=> $stable(ex_valid) && $stable(ex_pc) && $stable(ex_rs1_data)
            && $stable(ex_rs2_data) && $stable(ex_imm) && $stable(ex_rd) && $stable(ex_ctrl))
        else $error("ID/EX outputs changed during a stall");

    illegal_has_no_writes: assert property (@(posedge clk) disable iff (!rst_n)
        ex_ctrl[pipe_stage_pkg::CTRL_ILLEGAL] |-> !reg_write && !mem_read && !mem_write)
        else $error("illegal instruction carries a write enable");

endmodule

bind id_ex_buffer decode_props u_decode_props (
    .clk         (clk),
    .rst_n       (rst_n),
    .stall       (stall),
    .flush       (flush),
    .ex_valid    (ex_valid),
    .ex_pc       (ex_pc),
    .ex_rs1_data (ex_rs1_data),
    .ex_rs2_data (ex_rs2_data),
    .ex_imm      (ex_imm),
    .ex_rd       (ex_rd),
    .ex_ctrl     (ex_ctrl)
);

// File: verification/decode_tb.sv
`timescale 1ns/1ns
`include "decode_config.svh"

module decode_tb;
    // words per vector line, and room for the vector file.
    localparam int fields      = 16;
    localparam int max_vectors = 64;

    // enables that a bubble must clear.
    localparam pipe_stage_pkg::ctrl_word_t enable_mask =
        (pipe_stage_pkg::ctrl_word_t'(1) << pipe_stage_pkg::CTRL_REG_WRITE) |
        (pipe_stage_pkg::ctrl_word_t'(1) << pipe_stage_pkg::CTRL_MEM_READ)  |
        (pipe_stage_pkg::ctrl_word_t'(1) << pipe_stage_pkg::CTRL_MEM_WRITE) |
        (pipe_stage_pkg::ctrl_word_t'(1) << pipe_stage_pkg::CTRL_BRANCH)    |
        (pipe_stage_pkg::ctrl_word_t'(1) << pipe_stage_pkg::CTRL_JUMP);
    localparam pipe_stage_pkg::ctrl_word_t reset_mask =
        enable_mask | (pipe_stage_pkg::ctrl_word_t'(1) << pipe_stage_pkg::CTRL_ILLEGAL);

    logic                       clk;
    logic                       rst_n;
    logic                       in_valid;
    rv32i_isa_pkg::rv32i_word   in_pc;
    rv32i_isa_pkg::rv32i_word   in_instr;
    logic                       stall;
    logic                       flush;
    logic                       wb_load;
    rv32i_isa_pkg::rv32i_reg    wb_rd;
    rv32i_isa_pkg::rv32i_word   wb_data;
    logic                       ex_valid;
    rv32i_isa_pkg::rv32i_word   ex_pc;
    rv32i_isa_pkg::rv32i_word   ex_rs1_data;
    rv32i_isa_pkg::rv32i_word   ex_rs2_data;
    rv32i_isa_pkg::rv32i_word   ex_imm;
    rv32i_isa_pkg::rv32i_reg    ex_rd;
    pipe_stage_pkg::ctrl_word_t ex_ctrl;

    logic [31:0] vectors [0:fields*max_vectors-1];
    int          num_vectors;
    int          cycle_count = 0;
    int          cycle_limit = 20;

    decode_stage_top UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .in_valid    (in_valid),
        .in_pc       (in_pc),
        .in_instr    (in_instr),
        .stall       (stall),
        .flush       (flush),
        .wb_load     (wb_load),
        .wb_rd       (wb_rd),
        .wb_data     (wb_data),
        .ex_valid    (ex_valid),
        .ex_pc       (ex_pc),
        .ex_rs1_data (ex_rs1_data),
        .ex_rs2_data (ex_rs2_data),
        .ex_imm      (ex_imm),
        .ex_rd       (ex_rd),
        .ex_ctrl     (ex_ctrl)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_word(input string name, input rv32i_isa_pkg::rv32i_word got,
                              input rv32i_isa_pkg::rv32i_word exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_reg(input string name, input rv32i_isa_pkg::rv32i_reg got,
                             input rv32i_isa_pkg::rv32i_reg exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_ctrl(input string name, input pipe_stage_pkg::ctrl_word_t got,
                              input pipe_stage_pkg::ctrl_word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, name, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic drive_vector(input int idx);
        int base;
        base     = idx * fields;
        in_valid = vectors[base][0];
        stall    = vectors[base + 1][0];
        flush    = vectors[base + 2][0];
        wb_load  = vectors[base + 3][0];
        wb_rd    = vectors[base + 4][4:0];
        wb_data  = vectors[base + 5];
        in_pc    = vectors[base + 6];
        in_instr = vectors[base + 7];
    endtask

    // bubble lines only check valid and the enables.
    task automatic check_vector(input int idx);
        int                         base;
        pipe_stage_pkg::ctrl_word_t exp_ctrl;
        base     = idx * fields;
        exp_ctrl = vectors[base + 15][pipe_stage_pkg::CTRL_W-1:0];
        check_bit("ex_valid", ex_valid, vectors[base + 9][0]);
        if (vectors[base + 8][0]) begin
            check_word("ex_pc", ex_pc, vectors[base + 10]);
            check_word("ex_rs1_data", ex_rs1_data, vectors[base + 11]);
            check_word("ex_rs2_data", ex_rs2_data, vectors[base + 12]);
            check_word("ex_imm", ex_imm, vectors[base + 13]);
            check_reg("ex_rd", ex_rd, vectors[base + 14][4:0]);
            check_ctrl("ex_ctrl", ex_ctrl, exp_ctrl);
        end else begin
            check_ctrl("ex_ctrl enables", ex_ctrl & enable_mask, exp_ctrl & enable_mask);
        end
    endtask

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: the run did not end within %0d clock cycles", cycle_limit);
            stop_with_failure();
        end
    end

    initial begin
        int idx;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_pc    = '0;
        in_instr = '0;
        stall    = 1'b0;
        flush    = 1'b0;
        wb_load  = 1'b0;
        wb_rd    = '0;
        wb_data  = '0;
        $readmemh("verification/decode_vectors.txt", vectors);
        // the list ends at a line whose first word is f.
        num_vectors = 0;
        while (num_vectors < max_vectors && vectors[num_vectors * fields] !== 32'hf) begin
            num_vectors = num_vectors + 1;
        end
        if (num_vectors == 0 || num_vectors == max_vectors) begin
            $display("Vector file is empty or has no end marker");
            stop_with_failure();
        end
        cycle_limit = num_vectors + 20;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        check_bit("ex_valid after reset", ex_valid, 1'b0);
        check_ctrl("ex_ctrl after reset", ex_ctrl & reset_mask, '0);
        check_word("ex_pc after reset", ex_pc, `RESET_PC);
        for (idx = 0; idx < num_vectors; idx++) begin
            drive_vector(idx);
            @(posedge clk);
            #2;
            check_vector(idx);
        end
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

// File: verification/decode_vectors.txt
// in: in_valid stall flush wb_load wb_rd wb_data in_pc in_instr
// out next cycle: full_check ex_valid ex_pc ex_rs1 ex_rs2 ex_imm ex_rd ex_ctrl
// write-back of x1, x2 and x0, then register reads
1 0 0 1 01 11112222 00000100 00000013  1 1 00000100 00000000 00000000 00000000 00 0a0
1 0 0 1 02 80000003 00000104 00000013  1 1 00000104 00000000 00000000 00000000 00 0a0
1 0 0 1 00 deadbeef 00000108 002081b3  1 1 00000108 11112222 80000003 00000000 03 020
1 0 0 1 00 55aa55aa 0000010c 40100233  1 1 0000010c 00000000 11112222 00000000 04 120
// sra, srai, lw, sw, beq, lui, jal with the sign bit clear and set
1 0 0 0 00 00000000 00000110 401152b3  1 1 00000110 80000003 11112222 00000000 05 720
1 0 0 0 00 00000000 00000114 40415313  1 1 00000114 80000003 00000000 00000404 06 7a0
1 0 0 0 00 00000000 00000118 ffc0a383  1 1 00000118 11112222 00000000 fffffffc 07 0b0
1 0 0 0 00 00000000 0000011c 0020a423  1 1 0000011c 11112222 80000003 00000008 08 088
1 0 0 0 00 00000000 00000120 fe112a23  1 1 00000120 80000003 11112222 fffffff4 14 088
1 0 0 0 00 00000000 00000124 00208863  1 1 00000124 11112222 80000003 00000010 10 0c4
1 0 0 0 00 00000000 00000128 fe000ce3  1 1 00000128 00000000 00000000 fffffff8 19 0c4
1 0 0 0 00 00000000 0000012c 12345437  1 1 0000012c 00000000 00000000 12345000 08 aa0
1 0 0 0 00 00000000 00000130 fffff4b7  1 1 00000130 00000000 00000000 fffff000 09 aa0
1 0 0 0 00 00000000 00000134 010000ef  1 1 00000134 00000000 00000000 00000010 01 0e2
1 0 0 0 00 00000000 00000138 ffdff06f  1 1 00000138 00000000 00000000 fffffffc 00 0e2
1 0 0 0 00 00000000 0000013c ffffffff  1 1 0000013c 00000000 00000000 00000000 1f 001
// write and read of x10 in the same cycle
1 0 0 1 0a cafef00d 00000140 00a505b3  1 1 00000140 cafef00d cafef00d 00000000 0b 020
// stall, flush, flush with stall, in_valid low
1 0 0 0 00 00000000 00000200 002081b3  1 1 00000200 11112222 80000003 00000000 03 020
1 1 0 0 00 00000000 00000204 40100233  1 1 00000200 11112222 80000003 00000000 03 020
1 0 1 0 00 00000000 00000208 ffc0a383  0 0 00000000 00000000 00000000 00000000 00 000
1 0 0 0 00 00000000 0000020c ffc0a383  1 1 0000020c 11112222 00000000 fffffffc 07 0b0
1 1 1 0 00 00000000 00000210 0020a423  0 0 00000000 00000000 00000000 00000000 00 000
0 0 0 0 00 00000000 00000214 ffc0a383  0 0 00000000 00000000 00000000 00000000 00 000
1 0 0 0 00 00000000 00000218 010000ef  1 1 00000218 00000000 00000000 00000010 01 0e2
0 1 0 0 00 00000000 0000021c ffc0a383  1 1 00000218 00000000 00000000 00000010 01 0e2
// end marker
f

// File: flist.f
+incdir+include
logic/rv32i_isa_pkg.sv
logic/pipe_stage_pkg.sv
logic/control_word.sv
logic/regfile.sv
logic/id_ex_if.sv
logic/i_decode.sv
logic/id_ex_buffer.sv
logic/decode_stage_top.sv
verification/decode_props.sv
verification/decode_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the decode stage testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timescale 1ns/1ns --top-module decode_tb \
    -f flist.f -Mdir obj_dir -o decode_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/decode_sim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi
exit 0
